// File: include/mem_subsys_config.svh
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Byte address of the first word of the RAM window
`define RAM_BASE 32'h8000_0000

// Default RAM size in 32-bit words
`define RAM_DEPTH 1024

// Byte offset within the window where instruction fetch stops being legal.
// Sits at the middle of the default window.
`define RAM_XN_OFFSET (`RAM_DEPTH * 2)

`endif

// File: hdl/mem_pkg.sv
package mem_pkg;

	// Request as presented by the core.
	// A request with no strobes set is a read.
	typedef struct packed {
		// Instruction fetch flag
		logic        instr;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} mem_req_t;

	// Response, valid in the cycle where the enable is high and stall is low
	typedef struct packed {
		logic [31:0] rdata;
		// Slave answered SLVERR or DECERR
		logic        error;
	} mem_rsp_t;

endpackage

// File: hdl/axi_lite_pkg.sv
package axi_lite_pkg;

	// Response codes shared by B and R
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// AxPROT bit 2 marks an instruction access
	localparam logic [2:0] PROT_INSTR = 3'b100;
	localparam logic [2:0] PROT_DATA  = 3'b000;

	// Write address channel
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  prot;
	} axi_aw_t;

	// Write data channel
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_w_t;

	// Write response channel
	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

	// Read address channel
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  prot;
	} axi_ar_t;

	// Read data channel
	typedef struct packed {
		logic [31:0] data;
		axi_resp_e   resp;
	} axi_r_t;

endpackage

// File: hdl/sram_axi_adapter.sv
`timescale 1ns/1ns

module sram_axi_adapter (
	input  logic                  g_clk,
	input  logic                  g_resetn,

	// Core side
	input  logic                  mem_cen,
	input  mem_pkg::mem_req_t     mem_req,
	output logic                  mem_stall,
	output mem_pkg::mem_rsp_t     mem_rsp,

	// AXI4-Lite master
	output logic                  aw_valid,
	input  logic                  aw_ready,
	output axi_lite_pkg::axi_aw_t aw,

	output logic                  w_valid,
	input  logic                  w_ready,
	output axi_lite_pkg::axi_w_t  w,

	input  logic                  b_valid,
	output logic                  b_ready,
	input  axi_lite_pkg::axi_b_t  b,

	output logic                  ar_valid,
	input  logic                  ar_ready,
	output axi_lite_pkg::axi_ar_t ar,

	input  logic                  r_valid,
	output logic                  r_ready,
	input  axi_lite_pkg::axi_r_t  r
);
	logic       is_write;
	logic [2:0] prot;
	logic       rsp_seen;
	logic       xfer_done;

	// Handshake already seen for the current request
	logic ack_aw;
	logic ack_w;
	logic ack_ar;

	assign is_write = |mem_req.strb;
	assign prot = mem_req.instr ? axi_lite_pkg::PROT_INSTR : axi_lite_pkg::PROT_DATA;

	// Each valid falls once its own handshake is done
	assign aw_valid = mem_cen && is_write && !ack_aw;
	assign w_valid  = mem_cen && is_write && !ack_w;
	assign ar_valid = mem_cen && !is_write && !ack_ar;

	assign aw.addr = mem_req.addr;
	assign aw.prot = prot;
	assign w.data  = mem_req.wdata;
	assign w.strb  = mem_req.strb;
	assign ar.addr = mem_req.addr;
	assign ar.prot = prot;

	assign b_ready = mem_cen && is_write;
	// Read responses are never held off
	assign r_ready = 1'b1;

	// Response path is purely combinational
	assign rsp_seen  = is_write ? b_valid : r_valid;
	assign mem_stall = !rsp_seen;
	assign xfer_done = mem_cen && rsp_seen;

	assign mem_rsp.rdata = r.data;
	always_comb begin
		if (is_write) begin
			mem_rsp.error = (b.resp == axi_lite_pkg::SLVERR) ||
				(b.resp == axi_lite_pkg::DECERR);
		end else begin
			mem_rsp.error = (r.resp == axi_lite_pkg::SLVERR) ||
				(r.resp == axi_lite_pkg::DECERR);
		end
	end

	// Flags drop at completion so the next request can start right away
	always_ff @(posedge g_clk) begin
		if (!g_resetn) begin
			ack_aw <= 1'b0;
			ack_w  <= 1'b0;
			ack_ar <= 1'b0;
		end else if (!mem_cen || xfer_done) begin
			ack_aw <= 1'b0;
			ack_w  <= 1'b0;
			ack_ar <= 1'b0;
		end else begin
			if (aw_valid && aw_ready)
				ack_aw <= 1'b1;
			if (w_valid && w_ready)
				ack_w <= 1'b1;
			if (ar_valid && ar_ready)
				ack_ar <= 1'b1;
		end
	end

endmodule

// File: hdl/axi_lite_ram.sv
`timescale 1ns/1ns

`include "mem_subsys_config.svh"

module axi_lite_ram #(
	parameter int DEPTH = `RAM_DEPTH
) (
	input  logic                  g_clk,
	input  logic                  g_resetn,

	input  logic                  aw_valid,
	output logic                  aw_ready,
	input  axi_lite_pkg::axi_aw_t aw,

	input  logic                  w_valid,
	output logic                  w_ready,
	input  axi_lite_pkg::axi_w_t  w,

	output logic                  b_valid,
	input  logic                  b_ready,
	output axi_lite_pkg::axi_b_t  b,

	input  logic                  ar_valid,
	output logic                  ar_ready,
	input  axi_lite_pkg::axi_ar_t ar,

	output logic                  r_valid,
	input  logic                  r_ready,
	output axi_lite_pkg::axi_r_t  r
);
	localparam int          IDX_W     = $clog2(DEPTH);
	localparam logic [31:0] WIN_BYTES = DEPTH * 4;
	localparam logic [31:0] XN_OFFSET = `RAM_XN_OFFSET;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} rd_state_e;

	wr_state_e wr_state;
	rd_state_e rd_state;

	logic [31:0] mem [DEPTH];

	logic                   wr_fire;
	logic                   rd_fire;
	axi_lite_pkg::axi_resp_e wr_check;
	axi_lite_pkg::axi_resp_e rd_check;
	logic [IDX_W-1:0]       wr_idx;
	logic [IDX_W-1:0]       rd_idx;

	// Window decode plus the no-execute rule for the upper part.
	// Writes carrying the instruction bit get the same treatment.
	function automatic axi_lite_pkg::axi_resp_e check_access(
		input logic [31:0] addr,
		input logic [2:0]  prot
	);
		logic [31:0] offset;
		offset = addr - `RAM_BASE;
		if (addr < `RAM_BASE || offset >= WIN_BYTES)
			return axi_lite_pkg::DECERR;
		if ((prot & axi_lite_pkg::PROT_INSTR) != 3'b000 && offset >= XN_OFFSET)
			return axi_lite_pkg::SLVERR;
		return axi_lite_pkg::OKAY;
	endfunction

	function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - `RAM_BASE;
		return offset[IDX_W+1:2];
	endfunction

	// Address and data are taken together, and only with no B pending
	assign aw_ready = (wr_state == WR_IDLE) && aw_valid && w_valid;
	assign w_ready  = aw_ready;
	assign ar_ready = (rd_state == RD_IDLE) && ar_valid;

	assign b_valid = (wr_state == WR_RESP);
	assign r_valid = (rd_state == RD_RESP);

	assign wr_fire  = aw_valid && aw_ready;
	assign rd_fire  = ar_valid && ar_ready;
	assign wr_check = check_access(aw.addr, aw.prot);
	assign rd_check = check_access(ar.addr, ar.prot);
	assign wr_idx   = word_index(aw.addr);
	assign rd_idx   = word_index(ar.addr);

	always_ff @(posedge g_clk) begin
		if (!g_resetn) begin
			wr_state <= WR_IDLE;
			rd_state <= RD_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: if (wr_fire) wr_state <= WR_RESP;
				WR_RESP: if (b_ready) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
			case (rd_state)
				RD_IDLE: if (rd_fire) rd_state <= RD_RESP;
				RD_RESP: if (r_ready) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// Response payloads, meaningful only while the matching valid is high
	always_ff @(posedge g_clk) begin
		if (wr_fire)
			b.resp <= wr_check;
		if (rd_fire) begin
			r.resp <= rd_check;
			if (rd_check == axi_lite_pkg::OKAY)
				r.data <= mem[rd_idx];
			else
				r.data <= '0;
		end
	end

	// Byte-lane writes, dropped entirely on a failed check
	always_ff @(posedge g_clk) begin
		if (wr_fire && wr_check == axi_lite_pkg::OKAY) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

endmodule

// File: hdl/mem_subsys_top.sv
`timescale 1ns/1ns

`include "mem_subsys_config.svh"

module mem_subsys_top #(
	parameter int DEPTH = `RAM_DEPTH
) (
	input  logic              g_clk,
	input  logic              g_resetn,
	input  logic              mem_cen,
	input  mem_pkg::mem_req_t mem_req,
	output logic              mem_stall,
	output mem_pkg::mem_rsp_t mem_rsp
);
	// AXI4-Lite link between adapter and RAM
	logic                  aw_valid;
	logic                  aw_ready;
	axi_lite_pkg::axi_aw_t aw;
	logic                  w_valid;
	logic                  w_ready;
	axi_lite_pkg::axi_w_t  w;
	logic                  b_valid;
	logic                  b_ready;
	axi_lite_pkg::axi_b_t  b;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_lite_pkg::axi_ar_t ar;
	logic                  r_valid;
	logic                  r_ready;
	axi_lite_pkg::axi_r_t  r;

	sram_axi_adapter adapter (
		.g_clk    (g_clk),
		.g_resetn (g_resetn),
		.mem_cen  (mem_cen),
		.mem_req  (mem_req),
		.mem_stall(mem_stall),
		.mem_rsp  (mem_rsp),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.aw       (aw),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.w        (w),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.b        (b),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar       (ar),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.r        (r)
	);

	axi_lite_ram #(
		.DEPTH(DEPTH)
	) ram (
		.g_clk    (g_clk),
		.g_resetn (g_resetn),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.aw       (aw),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.w        (w),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.b        (b),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar       (ar),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.r        (r)
	);

endmodule

// File: test/mem_subsys_chk.sv
`timescale 1ns/1ns

module mem_subsys_chk (
	input logic                  g_clk,
	input logic                  g_resetn,
	input logic                  aw_valid,
	input logic                  aw_ready,
	input axi_lite_pkg::axi_aw_t aw,
	input logic                  w_valid,
	input logic                  w_ready,
	input axi_lite_pkg::axi_w_t  w,
	input logic                  b_valid,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input axi_lite_pkg::axi_ar_t ar,
	input logic                  r_valid
);
	// Number of failed assertions
	int unsigned fail_count = 0;

	// A valid held off by ready keeps its payload
	aw_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			$error("AW valid dropped or payload changed before AWREADY");
			fail_count++;
		end

	w_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			$error("W valid dropped or payload changed before WREADY");
			fail_count++;
		end

	ar_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			$error("AR valid dropped or payload changed before ARREADY");
			fail_count++;
		end

	// Responses only follow an accepted request
	r_after_ar: assert property (@(posedge g_clk) disable iff (!g_resetn)
		$rose(r_valid) |-> $past(ar_valid && ar_ready))
		else begin
			$error("RVALID rose without an accepted AR");
			fail_count++;
		end

	b_after_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
		$rose(b_valid) |-> $past(aw_valid && aw_ready && w_valid && w_ready))
		else begin
			$error("BVALID rose without an accepted write");
			fail_count++;
		end

endmodule

bind axi_lite_ram mem_subsys_chk chk (.*);

// File: test/mem_subsys_tb.sv
`timescale 1ns/1ns

`include "mem_subsys_config.svh"

module mem_subsys_tb;
	localparam int          DEPTH     = `RAM_DEPTH;
	localparam int          XN_WORDS  = `RAM_XN_OFFSET / 4;
	localparam logic [31:0] WIN_BYTES = DEPTH * 4;
	localparam logic [31:0] XN_OFFSET = `RAM_XN_OFFSET;
	localparam int          TIMEOUT   = 16;

	logic              g_clk;
	logic              g_resetn;
	logic              mem_cen;
	mem_pkg::mem_req_t mem_req;
	logic              mem_stall;
	mem_pkg::mem_rsp_t mem_rsp;

	// Reference copy of the RAM contents
	logic [31:0] model_mem [DEPTH];
	logic [31:0] addr;

	mem_subsys_top #(
		.DEPTH(DEPTH)
	) uut (
		.g_clk    (g_clk),
		.g_resetn (g_resetn),
		.mem_cen  (mem_cen),
		.mem_req  (mem_req),
		.mem_stall(mem_stall),
		.mem_rsp  (mem_rsp)
	);

	initial begin
		g_clk = 1'b0;
		forever #50 g_clk = ~g_clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Word address relative to the window base, first plus a random step below count
	function automatic logic [31:0] pick_addr(input int first, input int count);
		int word;
		word = first + int'($urandom % 32'(count));
		return `RAM_BASE + 32'(4 * word);
	endfunction

	// One core transfer, checked against the model
	task automatic run_request(input logic instr, input logic [31:0] a,
			input logic [31:0] wdata, input logic [3:0] strb, input logic hold);
		logic [31:0]       offset;
		logic              fault;
		logic [31:0]       exp_data;
		int                idx;
		int                cycles;
		mem_pkg::mem_rsp_t got;
		offset = a - `RAM_BASE;
		idx = int'(offset >> 2);
		// Out of window, or a fetch in the no-execute half
		fault = (a < `RAM_BASE) || (offset >= WIN_BYTES) ||
			(instr && offset >= XN_OFFSET);
		exp_data = 32'h0;
		if (!fault)
			exp_data = model_mem[idx];
		mem_cen = 1'b1;
		mem_req.instr = instr;
		mem_req.addr  = a;
		mem_req.wdata = wdata;
		mem_req.strb  = strb;
		cycles = 0;
		@(negedge g_clk);
		while (mem_stall) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timeout: no response to the request at address %h", a);
				$display("TESTBENCH FAILED");
				$fatal(1, "Request timed out");
			end
			@(negedge g_clk);
		end
		got = mem_rsp;
		check_value("mem_rsp.error", 32'(got.error), 32'(fault));
		if (strb == 4'h0) begin
			check_value("mem_rsp.rdata", got.rdata, exp_data);
		end else if (!fault) begin
			for (int i = 0; i < 4; i++) begin
				if (strb[i])
					model_mem[idx][8*i +: 8] = wdata[8*i +: 8];
			end
		end
		@(posedge g_clk);
		#1;
		if (!hold) begin
			mem_cen = 1'b0;
			mem_req = '0;
			@(negedge g_clk);
			check_value("mem_stall", 32'(mem_stall), 32'd1);
			@(posedge g_clk);
			#1;
		end
	endtask

	initial begin
		int unsigned kind;
		logic [3:0]  strb;
		void'($urandom(64713));
		g_resetn = 1'b0;
		mem_cen  = 1'b0;
		mem_req  = '0;

		// Stall stays high through reset and while idle afterwards
		repeat (8) begin
			@(posedge g_clk);
			#1;
			check_value("mem_stall", 32'(mem_stall), 32'd1);
		end
		g_resetn = 1'b1;
		repeat (3) begin
			@(negedge g_clk);
			check_value("mem_stall", 32'(mem_stall), 32'd1);
			check_value("ram b_valid r_valid", 32'({uut.ram.b_valid, uut.ram.r_valid}), 32'd0);
		end
		@(posedge g_clk);
		#1;

		// Fill every word so that later reads have known contents
		for (int i = 0; i < DEPTH; i++)
			run_request(1'b0, `RAM_BASE + 32'(4 * i), $urandom, 4'hf, (i % 5) != 0);

		// Partial and full writes, each read back
		repeat (200) begin
			addr = pick_addr(0, DEPTH);
			strb = 4'($urandom_range(1, 15));
			run_request(1'b0, addr, $urandom, strb, 1'b0);
			run_request(1'b0, addr, 32'h0, 4'h0, 1'b0);
		end

		// Outside the window, then the word that shares its index
		repeat (40) begin
			if ($urandom % 2 == 0)
				addr = pick_addr(-64, 64);
			else
				addr = pick_addr(DEPTH, 64);
			run_request(1'b0, addr, $urandom, 4'($urandom_range(1, 15)), 1'b0);
			run_request(1'b0, addr, 32'h0, 4'h0, 1'b0);
			run_request(1'b0, `RAM_BASE + ((addr - `RAM_BASE) & (WIN_BYTES - 1)),
				32'h0, 4'h0, 1'b0);
		end

		// Fetches on both sides of the no-execute boundary
		repeat (40) begin
			run_request(1'b1, pick_addr(0, XN_WORDS), 32'h0, 4'h0, 1'b0);
			addr = pick_addr(XN_WORDS, DEPTH - XN_WORDS);
			run_request(1'b1, addr, 32'h0, 4'h0, 1'b0);
			run_request(1'b0, addr, 32'h0, 4'h0, 1'b0);
			run_request(1'b1, addr, $urandom, 4'hf, 1'b0);
			run_request(1'b0, addr, 32'h0, 4'h0, 1'b0);
		end

		// Back-to-back mix with the enable held high
		repeat (400) begin
			kind = $urandom % 8;
			if (kind == 0)
				addr = pick_addr(-32, 32);
			else if (kind == 1)
				addr = pick_addr(DEPTH, 32);
			else
				addr = pick_addr(0, DEPTH);
			strb = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom_range(1, 15));
			run_request(($urandom % 4) == 0, addr, $urandom, strb, 1'b1);
		end
		mem_cen = 1'b0;
		mem_req = '0;
		@(negedge g_clk);
		check_value("mem_stall", 32'(mem_stall), 32'd1);

		if (uut.ram.chk.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Assertion failures seen on the AXI4-Lite channels");
			$display("TESTBENCH FAILED");
			$fatal(1, "Protocol assertions failed");
		end
	end

endmodule

// File: mem_subsys_top.f
+incdir+include
hdl/mem_pkg.sv
hdl/axi_lite_pkg.sv
hdl/sram_axi_adapter.sv
hdl/axi_lite_ram.sv
hdl/mem_subsys_top.sv
test/mem_subsys_chk.sv
test/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
